//--- logic/calc_pkg.sv
// --------------------------------------------------------------------------
// Fixed RV64 widths; only OP/OP-IMM ALU forms and mul are decoded as legal.
// --------------------------------------------------------------------------
package calc_pkg;

  parameter int dword_width    = 64;
  parameter int reg_addr_width = 5;
  parameter int comp_stages    = 4;

  // Major opcodes
  parameter logic [6:0] opcode_op     = 7'b0110011;
  parameter logic [6:0] opcode_op_imm = 7'b0010011;

  parameter logic [2:0] funct3_add = 3'b000;
  parameter logic [2:0] funct3_sll = 3'b001;
  parameter logic [2:0] funct3_xor = 3'b100;
  parameter logic [2:0] funct3_or  = 3'b110;
  parameter logic [2:0] funct3_and = 3'b111;
  parameter logic [2:0] funct3_mul = 3'b000;

  parameter logic [6:0] funct7_base = 7'b0000000;
  parameter logic [6:0] funct7_sub  = 7'b0100000;
  parameter logic [6:0] funct7_mul  = 7'b0000001;

  typedef struct packed {
    logic [6:0]                funct7;
    logic [reg_addr_width-1:0] rs2_addr;
    logic [reg_addr_width-1:0] rs1_addr;
    logic [2:0]                funct3;
    logic [reg_addr_width-1:0] rd_addr;
    logic [6:0]                opcode;
  } rtype_s;

  typedef struct packed {
    logic [11:0]               imm;
    logic [reg_addr_width-1:0] rs1_addr;
    logic [2:0]                funct3;
    logic [reg_addr_width-1:0] rd_addr;
    logic [6:0]                opcode;
  } itype_s;

  // Same 32-bit word, register or immediate layout
  typedef union packed {
    rtype_s rtype;
    itype_s itype;
  } instr_u;

  typedef struct packed {
    logic                   v;
    logic [31:0]            pc;
    instr_u                 instr;
    logic [dword_width-1:0] rs1_data;
    logic [dword_width-1:0] rs2_data;
  } dispatch_pkt_s;

  typedef struct packed {
    logic irs1_r_v;
    logic irs2_r_v;
    logic irf_w_v;
    logic int_v;
    logic mul_v;
    logic use_imm;
    logic illegal;
  } decode_s;

  typedef struct packed {
    dispatch_pkt_s pkt;
    decode_s       decode;
  } reservation_s;

  typedef struct packed {
    logic                      w_v;
    logic [reg_addr_width-1:0] rd_addr;
    logic [dword_width-1:0]    data;
  } wb_pkt_s;

  // Tag of a completion stage with the data it holds one cycle later
  typedef struct packed {
    logic                      w_v;
    logic [reg_addr_width-1:0] rd_addr;
    logic [dword_width-1:0]    data;
  } fwd_s;

  typedef struct packed {
    logic        v;
    logic        illegal;
    logic [31:0] pc;
  } exc_stage_s;

  typedef struct packed {
    logic        v;
    logic        illegal;
    logic [31:0] pc;
  } commit_pkt_s;

endpackage

//--- logic/calc_issue.sv
// --------------------------------------------------------------------------
// Dispatch is sampled every cycle with no back-pressure; flush drops it.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module calc_issue
 (input                                                      clk_i
  , input                                                    rst_n_i
  , input  calc_pkg::dispatch_pkt_s                          dispatch_pkt_i
  , input  calc_pkg::fwd_s [calc_pkg::comp_stages-1:0]       fwd_i
  , input                                                    flush_i
  , output calc_pkg::reservation_s                           reservation_o
  );

  import calc_pkg::*;

  instr_u       instr;
  decode_s      decode;
  logic         alu_f3_v;
  reservation_s reservation_n;
  reservation_s reservation_r;

  // Youngest in-flight producer of addr, else the register file value
  function automatic logic [dword_width-1:0] fwd_pick
    (input fwd_s [comp_stages-1:0]    fwd
     , input logic                    r_v
     , input logic [reg_addr_width-1:0] addr
     , input logic [dword_width-1:0]  file_data
     );
    logic [dword_width-1:0] data;
    data = file_data;
    for (int i = comp_stages-1; i >= 0; i--)
    begin
      if (r_v && fwd[i].w_v && (fwd[i].rd_addr == addr))
      begin
        data = fwd[i].data;
      end
    end
    return data;
  endfunction

  assign instr = dispatch_pkt_i.instr;

  // ALU funct3 values legal in both forms
  assign alu_f3_v = instr.rtype.funct3 inside {funct3_add, funct3_xor, funct3_or, funct3_and};

  always_comb
  begin
    decode = '0;
    case (instr.rtype.opcode)
      opcode_op:
      begin
        decode.irs1_r_v = 1'b1;
        decode.irs2_r_v = 1'b1;
        if (instr.rtype.funct7 == funct7_mul)
          decode.mul_v = (instr.rtype.funct3 == funct3_mul);
        else if (instr.rtype.funct7 == funct7_sub)
          decode.int_v = (instr.rtype.funct3 == funct3_add);
        else if (instr.rtype.funct7 == funct7_base)
          decode.int_v = alu_f3_v || (instr.rtype.funct3 == funct3_sll);
      end
      opcode_op_imm:
      begin
        decode.irs1_r_v = 1'b1;
        decode.use_imm  = 1'b1;
        decode.int_v    = alu_f3_v;
      end
      default:
        decode = '0;
    endcase

    decode.illegal = !(decode.int_v || decode.mul_v);
    if (decode.illegal)
    begin
      decode.irs1_r_v = 1'b0;
      decode.irs2_r_v = 1'b0;
    end
    // x0 is never written
    decode.irf_w_v = !decode.illegal && (instr.rtype.rd_addr != '0);
  end

  always_comb
  begin
    reservation_n            = '{pkt: dispatch_pkt_i, decode: decode};
    reservation_n.pkt.v      = dispatch_pkt_i.v && !flush_i;
    reservation_n.pkt.rs1_data = fwd_pick(fwd_i, decode.irs1_r_v, instr.rtype.rs1_addr,
                                          dispatch_pkt_i.rs1_data);
    reservation_n.pkt.rs2_data = fwd_pick(fwd_i, decode.irs2_r_v, instr.rtype.rs2_addr,
                                          dispatch_pkt_i.rs2_data);
  end

  always_ff @(posedge clk_i)
  begin
    reservation_r <= reservation_n;
    if (!rst_n_i)
    begin
      reservation_r.pkt.v <= 1'b0;
    end
  end

  assign reservation_o = reservation_r;

endmodule

//--- logic/calc_pipe_int.sv
// --------------------------------------------------------------------------
// Combinational ALU on the reservation; result lands in completion stage 1.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module calc_pipe_int
 (input  calc_pkg::reservation_s              reservation_i
  , output logic [calc_pkg::dword_width-1:0]  int_data_o
  , output logic                              int_v_o
  );

  import calc_pkg::*;

  instr_u                 instr;
  logic [dword_width-1:0] rs1;
  logic [dword_width-1:0] imm;
  logic [dword_width-1:0] opb;
  logic                   is_sub;

  assign instr = reservation_i.pkt.instr;
  assign rs1   = reservation_i.pkt.rs1_data;
  assign imm   = {{(dword_width-12){instr.itype.imm[11]}}, instr.itype.imm};
  assign opb   = reservation_i.decode.use_imm ? imm : reservation_i.pkt.rs2_data;

  // funct7 only means something in the register form
  assign is_sub = !reservation_i.decode.use_imm && (instr.rtype.funct7 == funct7_sub);

  assign int_v_o = reservation_i.pkt.v && reservation_i.decode.int_v;

  always_comb
  begin
    case (instr.rtype.funct3)
      funct3_add:
        int_data_o = is_sub ? (rs1 - opb) : (rs1 + opb);
      funct3_sll:
        int_data_o = rs1 << reservation_i.pkt.rs2_data[5:0];
      funct3_xor:
        int_data_o = rs1 ^ opb;
      funct3_or:
        int_data_o = rs1 | opb;
      funct3_and:
        int_data_o = rs1 & opb;
      default:
        int_data_o = '0;
    endcase
  end

endmodule

//--- logic/calc_pipe_mul.sv
// --------------------------------------------------------------------------
// Low 64 bits of the product, two registers after issue; fully pipelined.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module calc_pipe_mul
 (input                                       clk_i
  , input                                     rst_n_i
  , input  calc_pkg::reservation_s            reservation_i
  , output logic [calc_pkg::dword_width-1:0]  mul_data_o
  , output logic                              mul_v_o
  );

  import calc_pkg::*;

  logic                   mul_start;
  logic                   op_v_r;
  logic                   prod_v_r;
  logic [dword_width-1:0] op_a_r;
  logic [dword_width-1:0] op_b_r;
  logic [dword_width-1:0] prod_r;

  assign mul_start = reservation_i.pkt.v && reservation_i.decode.mul_v;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      op_v_r   <= 1'b0;
      prod_v_r <= 1'b0;
    end
    else
    begin
      op_v_r   <= mul_start;
      prod_v_r <= op_v_r;
    end
  end

  // Low half is the same for signed and unsigned operands
  always_ff @(posedge clk_i)
  begin
    if (mul_start)
    begin
      op_a_r <= reservation_i.pkt.rs1_data;
      op_b_r <= reservation_i.pkt.rs2_data;
    end
    if (op_v_r)
    begin
      prod_r <= op_a_r * op_b_r;
    end
  end

  assign mul_data_o = prod_r;
  assign mul_v_o    = prod_v_r;

endmodule

//--- logic/calc_comp_pipe.sv
// --------------------------------------------------------------------------
// Single issue with fixed latencies, so two pipes never finish together.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module calc_comp_pipe
 (input                                                   clk_i
  , input                                                 rst_n_i
  , input  calc_pkg::reservation_s                        reservation_i
  , input  logic [calc_pkg::dword_width-1:0]              int_data_i
  , input  logic                                          int_v_i
  , input  logic [calc_pkg::dword_width-1:0]              mul_data_i
  , input  logic                                          mul_v_i
  , input  logic [calc_pkg::comp_stages-1:0]              stage_v_i
  , output calc_pkg::fwd_s [calc_pkg::comp_stages-1:0]    fwd_o
  , output calc_pkg::wb_pkt_s                             wb_pkt_o
  );

  import calc_pkg::*;

  wb_pkt_s [comp_stages-1:0] stage_cur;
  wb_pkt_s [comp_stages-1:1] stage_n;
  wb_pkt_s [comp_stages-1:1] stage_r;

  // Stage 0 is the reservation itself and holds no data yet
  always_comb
  begin
    stage_cur[0].w_v     = reservation_i.decode.irf_w_v && stage_v_i[0];
    stage_cur[0].rd_addr = reservation_i.pkt.instr.rtype.rd_addr;
    stage_cur[0].data    = '0;
    stage_cur[comp_stages-1:1] = stage_r;
  end

  always_comb
  begin
    for (int i = 1; i < comp_stages; i++)
    begin
      stage_n[i]     = stage_cur[i-1];
      stage_n[i].w_v = stage_cur[i-1].w_v && stage_v_i[i];
    end
    stage_n[1].data |= int_v_i ? int_data_i : '0;
    stage_n[3].data |= mul_v_i ? mul_data_i : '0;
  end

  always_ff @(posedge clk_i)
  begin
    stage_r <= stage_n;
    if (!rst_n_i)
    begin
      for (int i = 1; i < comp_stages; i++)
      begin
        stage_r[i].w_v <= 1'b0;
      end
    end
  end

  for (genvar i = 0; i < comp_stages; i++)
  begin : g_fwd
    assign fwd_o[i].w_v     = stage_cur[i].w_v;
    assign fwd_o[i].rd_addr = stage_cur[i].rd_addr;
    if (i < comp_stages-1)
    begin : g_next
      assign fwd_o[i].data = stage_n[i+1].data;
    end
    else
    begin : g_last
      // Leaving the pipe this cycle, the register file is not written yet
      assign fwd_o[i].data = stage_cur[i].data;
    end
  end

  assign wb_pkt_o = stage_r[comp_stages-1];

endmodule

//--- logic/calc_ctrl.sv
// --------------------------------------------------------------------------
// Retires in order at stage 2; an illegal commit squashes the three younger.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module calc_ctrl
 (input                                        clk_i
  , input                                      rst_n_i
  , input  calc_pkg::reservation_s             reservation_i
  , input                                      dispatch_v_i
  , output logic [calc_pkg::comp_stages-1:0]   stage_v_o
  , output logic                               flush_o
  , output calc_pkg::commit_pkt_s              commit_pkt_o
  );

  import calc_pkg::*;

  exc_stage_s       exc_stage_0;
  exc_stage_s [2:1] exc_stage_n;
  exc_stage_s [2:1] exc_stage_r;
  logic             exc0_v_r;
  logic             retire_v;

  // Stage 0 lines up with the reservation register
  assign exc_stage_0.v       = exc0_v_r;
  assign exc_stage_0.illegal = exc0_v_r && reservation_i.decode.illegal;
  assign exc_stage_0.pc      = reservation_i.pkt.pc;

  assign commit_pkt_o.v       = exc_stage_r[2].v;
  assign commit_pkt_o.illegal = exc_stage_r[2].illegal;
  assign commit_pkt_o.pc      = exc_stage_r[2].pc;

  assign flush_o  = commit_pkt_o.illegal;
  assign retire_v = exc_stage_r[2].v && !exc_stage_r[2].illegal;

  always_comb
  begin
    exc_stage_n[1] = exc_stage_0;
    exc_stage_n[2] = exc_stage_r[1];
    // Squashed entries carry neither valid nor illegal
    if (flush_o)
    begin
      exc_stage_n[1].v       = 1'b0;
      exc_stage_n[1].illegal = 1'b0;
      exc_stage_n[2].v       = 1'b0;
      exc_stage_n[2].illegal = 1'b0;
    end
  end

  // Valid of the instruction entering each completion stage
  assign stage_v_o = {retire_v, exc_stage_n[2].v, exc_stage_n[1].v, exc_stage_0.v};

  always_ff @(posedge clk_i)
  begin
    exc_stage_r <= exc_stage_n;
    if (!rst_n_i)
    begin
      exc0_v_r               <= 1'b0;
      exc_stage_r[1].v       <= 1'b0;
      exc_stage_r[1].illegal <= 1'b0;
      exc_stage_r[2].v       <= 1'b0;
      exc_stage_r[2].illegal <= 1'b0;
    end
    else
    begin
      exc0_v_r <= dispatch_v_i && !flush_o;
    end
  end

endmodule

//--- logic/calc_top.sv
// --------------------------------------------------------------------------
// Writeback 4 cycles and commit 3 cycles after dispatch, for both pipes.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module calc_top
 (input                              clk_i
  , input                            rst_n_i
  , input  calc_pkg::dispatch_pkt_s  dispatch_pkt_i
  , output calc_pkg::wb_pkt_s        wb_pkt_o
  , output calc_pkg::commit_pkt_s    commit_pkt_o
  );

  import calc_pkg::*;

  reservation_s           reservation;
  fwd_s [comp_stages-1:0] fwd;
  logic [comp_stages-1:0] stage_v;
  logic                   flush;
  logic [dword_width-1:0] int_data;
  logic                   int_v;
  logic [dword_width-1:0] mul_data;
  logic                   mul_v;

  calc_ctrl u_ctrl
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.reservation_i(reservation)
    ,.dispatch_v_i(dispatch_pkt_i.v)
    ,.stage_v_o(stage_v)
    ,.flush_o(flush)
    ,.commit_pkt_o(commit_pkt_o)
    );

  calc_issue u_issue
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.dispatch_pkt_i(dispatch_pkt_i)
    ,.fwd_i(fwd)
    ,.flush_i(flush)
    ,.reservation_o(reservation)
    );

  calc_pipe_int u_pipe_int
   (.reservation_i(reservation)
    ,.int_data_o(int_data)
    ,.int_v_o(int_v)
    );

  calc_pipe_mul u_pipe_mul
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.reservation_i(reservation)
    ,.mul_data_o(mul_data)
    ,.mul_v_o(mul_v)
    );

  calc_comp_pipe u_comp_pipe
   (.clk_i(clk_i)
    ,.rst_n_i(rst_n_i)
    ,.reservation_i(reservation)
    ,.int_data_i(int_data)
    ,.int_v_i(int_v)
    ,.mul_data_i(mul_data)
    ,.mul_v_i(mul_v)
    ,.stage_v_i(stage_v)
    ,.fwd_o(fwd)
    ,.wb_pkt_o(wb_pkt_o)
    );

endmodule

//--- test/calc_assert.sv
// --------------------------------------------------------------------------
// Bound to calc_top; checks only the writeback and commit outputs.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module calc_assert
 (input                              clk_i
  , input                            rst_n_i
  , input  calc_pkg::wb_pkt_s        wb_pkt_i
  , input  calc_pkg::commit_pkt_s    commit_pkt_i
  );

  import calc_pkg::*;

  // Outputs stay quiet right after a reset edge
  quiet_after_reset: assert property (@(posedge clk_i)
    !rst_n_i |=> (!wb_pkt_i.w_v && !commit_pkt_i.v))
    else $error("output active in the cycle after reset");

  wb_rd_nonzero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_pkt_i.w_v |-> (wb_pkt_i.rd_addr != '0))
    else $error("writeback to register zero");

  illegal_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    commit_pkt_i.illegal |-> commit_pkt_i.v)
    else $error("commit illegal without commit valid");

endmodule

bind calc_top calc_assert u_calc_assert
 (.clk_i(clk_i)
  ,.rst_n_i(rst_n_i)
  ,.wb_pkt_i(wb_pkt_o)
  ,.commit_pkt_i(commit_pkt_o)
  );

//--- test/calc_tb.sv
// --------------------------------------------------------------------------
// Run from the project root; one stimulus line per cycle, 12 hex columns.
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module calc_tb;

  import calc_pkg::*;

  localparam int line_count   = 23;
  localparam int field_count  = 12;
  localparam int reset_cycles = 16;
  localparam int cycle_limit  = line_count + reset_cycles + 8;

  logic          clk;
  logic          rst_n;
  dispatch_pkt_s dispatch_pkt;
  wb_pkt_s       wb_pkt;
  commit_pkt_s   commit_pkt;
  logic [63:0]   stim [0:line_count*field_count-1];
  int            cycles = 0;
  int            errors = 0;
  int            checks = 0;
  int            test_errors = 0;
  int            tests_done = 0;
  int            cur_test = 0;

  calc_top u_calc_top
   (.clk_i(clk)
    ,.rst_n_i(rst_n)
    ,.dispatch_pkt_i(dispatch_pkt)
    ,.wb_pkt_o(wb_pkt)
    ,.commit_pkt_o(commit_pkt)
    );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= cycle_limit)
    begin
      $display("Timeout after %0d cycles, the stimulus did not finish", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic check_value(input string what, input logic [63:0] got,
                             input logic [63:0] expected);
    checks++;
    if (got !== expected)
    begin
      $display("Error %0t ns: %s is %h, expected %h", $time, what, got, expected);
      errors++;
      test_errors++;
    end
  endtask

  // Outputs seen now belong to instructions dispatched 3 and 4 lines earlier
  task automatic check_line(input int j);
    int b;
    b = j * field_count;
    check_value($sformatf("line %0d wb w_v", j), 64'(wb_pkt.w_v), stim[b+6]);
    if (stim[b+6][0])
    begin
      check_value($sformatf("line %0d wb rd", j), 64'(wb_pkt.rd_addr), stim[b+7]);
      check_value($sformatf("line %0d wb data", j), wb_pkt.data, stim[b+8]);
    end
    check_value($sformatf("line %0d commit v", j), 64'(commit_pkt.v), stim[b+9]);
    check_value($sformatf("line %0d commit illegal", j), 64'(commit_pkt.illegal),
                stim[b+10]);
    if (stim[b+9][0])
    begin
      check_value($sformatf("line %0d commit pc", j), 64'(commit_pkt.pc), stim[b+11]);
    end
  endtask

  task automatic drive_line(input int j);
    int b;
    b = j * field_count;
    dispatch_pkt.v        = stim[b+1][0];
    dispatch_pkt.pc       = stim[b+2][31:0];
    dispatch_pkt.instr    = stim[b+3][31:0];
    dispatch_pkt.rs1_data = stim[b+4];
    dispatch_pkt.rs2_data = stim[b+5];
  endtask

  task automatic report_test(input int id);
    $display("test %0d done, %0d errors", id, test_errors);
    tests_done++;
    test_errors = 0;
  endtask

  initial
  begin
    rst_n        = 1'b0;
    dispatch_pkt = '0;
    $readmemh("test/calc_stimulus.txt", stim);
    if ($isunknown(stim[line_count*field_count-1]))
    begin
      $display("The stimulus file could not be read completely");
      $display("Simulation failed");
      $finish;
    end
    else
    begin
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      cur_test = int'(stim[0]);
      for (int j = 0; j < line_count; j++)
      begin
        if (int'(stim[j*field_count]) != cur_test)
        begin
          report_test(cur_test);
          cur_test = int'(stim[j*field_count]);
        end
        check_line(j);
        drive_line(j);
        @(negedge clk);
      end
      report_test(cur_test);
      $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      if (errors == 0)
      begin
        $display("Simulation passed");
      end
      else
      begin
        $display("Simulation failed");
      end
      $finish;
    end
  end

endmodule

//--- test/calc_stimulus.txt
// test v pc instr rs1 rs2 | wb: w_v rd data | commit: v illegal pc
// Expected columns show outputs before this line is sampled
1 1 1000 003100B3 5 7                        0 0 0 0 0 0
1 1 1004 40628233 10 30                      0 0 0 0 0 0
1 1 1008 009413B3 3 44                       0 0 0 0 0 0
1 1 100C FFF5C513 FF 0                       0 0 0 1 0 1000
2 1 1010 10010293 23 0                       1 01 C 1 0 1004
2 1 1014 00528333 DEAD DEAD                  1 04 FFFFFFFFFFFFFFE0 1 0 1008
2 1 1018 0062C3B3 DEAD DEAD                  1 07 30 1 0 100C
2 1 101C 40530433 DEAD DEAD                  1 0A FFFFFFFFFFFFFF00 1 0 1010
2 1 1020 0072F4B3 DEAD DEAD                  1 05 123 1 0 1014
3 1 1024 02C58533 FFFFFFFFFFFFFFFD 7         1 06 246 1 0 1018
3 1 1028 02F706B3 100000000 300              1 07 365 1 0 101C
3 0 102C 00000000 0 0                        1 08 123 1 0 1020
3 1 1030 00550813 BAD 0                      1 09 121 1 0 1024
4 1 1034 0000007F 0 0                        1 0A FFFFFFFFFFFFFFEB 1 0 1028
4 1 1038 00110893 1 0                        1 0D 30000000000 0 0 0
4 1 103C 00110893 1 0                        0 0 0 1 0 1030
4 1 1040 00110893 1 0                        1 10 FFFFFFFFFFFFFFF0 1 1 1034
4 1 1044 00210913 40 0                       0 0 0 0 0 0
5 1 1048 00710013 40 0                       0 0 0 0 0 0
5 0 104C 00000000 0 0                        0 0 0 0 0 0
5 0 1050 00000000 0 0                        0 0 0 1 0 1044
5 0 1054 00000000 0 0                        1 12 42 1 0 1048
5 0 1058 00000000 0 0                        0 0 0 0 0 0

//--- verilog.f
logic/calc_pkg.sv
logic/calc_issue.sv
logic/calc_pipe_int.sv
logic/calc_pipe_mul.sv
logic/calc_comp_pipe.sv
logic/calc_ctrl.sv
logic/calc_top.sv
test/calc_assert.sv
test/calc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module calc_tb \
  -f verilog.f -o calc_sim \
  && ./obj_dir/calc_sim | tee /dev/stderr | grep "^Simulation passed$" > /dev/null \
  && echo "PASS" \
  || { echo "FAIL"; exit 1; }
